// ==== design/rect_pkg.sv ====
package rect_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int CMD_ADDR_W = 8;
	localparam int CMD_DATA_W = 32;
	localparam int COORD_W    = 10;
	localparam int COLOR_W    = 8;
	localparam int PIX_ADDR_W = 19;

	// visible frame, row stride of the pixel buffer is the width
	localparam int FRAME_W = 640;
	localparam int FRAME_H = 480;

	// ========================================================================
	// shared types
	// ========================================================================
	typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
	typedef logic [CMD_DATA_W-1:0] cmd_word_t;
	typedef logic [COORD_W-1:0]    coord_t;
	typedef logic [COLOR_W-1:0]    color_t;
	typedef logic [PIX_ADDR_W-1:0] pix_addr_t;

	// ========================================================================
	// command block layout in the shared memory
	// ========================================================================
	// non-zero flag means a new rectangle is waiting
	localparam cmd_addr_t CMD_FLAG  = 8'd0;
	// corners, first one is the scan origin
	localparam cmd_addr_t CMD_X1    = 8'd1;
	localparam cmd_addr_t CMD_Y1    = 8'd2;
	localparam cmd_addr_t CMD_X2    = 8'd3;
	localparam cmd_addr_t CMD_Y2    = 8'd4;
	// fill colour, low byte only
	localparam cmd_addr_t CMD_COLOR = 8'd5;

endpackage

// ==== design/cmd_ram.sv ====
module cmd_ram (
	input  logic                iCLK,
	input  logic                we,
	input  rect_pkg::cmd_addr_t addr,
	input  rect_pkg::cmd_word_t wdata,
	output rect_pkg::cmd_word_t q
);
	import rect_pkg::*;

	// 256 x 32, maps onto one M10K block
	localparam int DEPTH = 2 ** CMD_ADDR_W;

	cmd_word_t mem [DEPTH];

	// single port
	// write and read share one address
	always_ff @(posedge iCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// registered read, one cycle after the address
	// same-address write gives the old word here
	always_ff @(posedge iCLK) begin
		q <= mem[addr];
	end

endmodule

// ==== design/cmd_arbiter.sv ====
module cmd_arbiter (
	input  logic                iCLK,
	input  logic                rst,
	// host side, single-cycle strobes
	input  logic                host_wr,
	input  logic                host_rd,
	input  rect_pkg::cmd_addr_t host_addr,
	input  rect_pkg::cmd_word_t host_wdata,
	output rect_pkg::cmd_word_t host_rdata,
	output logic                host_rd_valid,
	// engine side, request held until granted
	input  logic                seq_req,
	input  logic                seq_we,
	input  rect_pkg::cmd_addr_t seq_addr,
	input  rect_pkg::cmd_word_t seq_wdata,
	output logic                seq_gnt,
	output logic                seq_rvalid,
	output rect_pkg::cmd_word_t seq_rdata,
	// memory side
	output logic                ram_we,
	output rect_pkg::cmd_addr_t ram_addr,
	output rect_pkg::cmd_word_t ram_wdata,
	input  rect_pkg::cmd_word_t ram_q
);

	logic host_act;
	logic host_rd_ok;
	logic seq_rd_ok;
	logic rd_pend;
	logic rd_host;

	// ========================================================================
	// request side
	// ========================================================================
	// host owns the port whenever it strobes
	assign host_act = host_wr | host_rd;
	// write wins over a read in the same cycle
	assign host_rd_ok = host_rd & ~host_wr;

	// engine only gets the quiet cycles
	assign seq_gnt   = seq_req & ~host_act;
	assign seq_rd_ok = seq_gnt & ~seq_we;

	assign ram_we    = host_wr | (seq_gnt & seq_we);
	assign ram_addr  = host_act ? host_addr : seq_addr;
	assign ram_wdata = host_wr ? host_wdata : seq_wdata;

	// ========================================================================
	// return side
	// ========================================================================
	// remember who issued the read now in flight
	always_ff @(posedge iCLK) begin
		if (rst) begin
			rd_pend <= 1'b0;
			rd_host <= 1'b0;
		end else begin
			rd_pend <= host_rd_ok | seq_rd_ok;
			rd_host <= host_rd_ok;
		end
	end

	// both requesters see the same ram output
	// only the owner gets the valid
	assign host_rdata    = ram_q;
	assign seq_rdata     = ram_q;
	assign host_rd_valid = rd_pend & rd_host;
	assign seq_rvalid    = rd_pend & ~rd_host;

endmodule

// ==== design/cmd_sequencer.sv ====
module cmd_sequencer (
	input  logic                iCLK,
	input  logic                rst,
	// command memory request port
	output logic                seq_req,
	output logic                seq_we,
	output rect_pkg::cmd_addr_t seq_addr,
	output rect_pkg::cmd_word_t seq_wdata,
	input  logic                seq_gnt,
	input  logic                seq_rvalid,
	input  rect_pkg::cmd_word_t seq_rdata,
	// scan launch, fields valid with the strobe
	output logic                scan_start,
	output rect_pkg::coord_t    x1,
	output rect_pkg::coord_t    y1,
	output rect_pkg::coord_t    x2,
	output rect_pkg::coord_t    y2,
	output rect_pkg::color_t    color,
	input  logic                scan_done
);
	import rect_pkg::*;

	typedef enum logic [2:0] {
		ST_FLAG_REQ,
		ST_FLAG_WAIT,
		ST_FIELD_REQ,
		ST_FIELD_WAIT,
		ST_START,
		ST_DRAW,
		ST_CLEAR
	} state_t;

	state_t    state;
	cmd_addr_t field_idx;

	// ========================================================================
	// request outputs, decoded from state
	// ========================================================================
	// held steady while the arbiter keeps us waiting
	assign seq_req = (state == ST_FLAG_REQ) || (state == ST_FIELD_REQ) ||
		(state == ST_CLEAR);
	// only write ever issued is the flag clear
	assign seq_we    = (state == ST_CLEAR);
	assign seq_wdata = '0;

	always_comb begin
		if (state == ST_FIELD_REQ) begin
			seq_addr = field_idx;
		end else begin
			seq_addr = CMD_FLAG;
		end
	end

	assign scan_start = (state == ST_START);

	// ========================================================================
	// command FSM
	// ========================================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			state     <= ST_FLAG_REQ;
			field_idx <= CMD_X1;
		end else begin
			case (state)
				// poll the flag word
				ST_FLAG_REQ: begin
					if (seq_gnt) begin
						state <= ST_FLAG_WAIT;
					end
				end
				ST_FLAG_WAIT: begin
					if (seq_rvalid) begin
						if (seq_rdata != '0) begin
							field_idx <= CMD_X1;
							state     <= ST_FIELD_REQ;
						end else begin
							// nothing posted yet, ask again
							state <= ST_FLAG_REQ;
						end
					end
				end
				// x1, y1, x2, y2, colour in turn
				ST_FIELD_REQ: begin
					if (seq_gnt) begin
						state <= ST_FIELD_WAIT;
					end
				end
				ST_FIELD_WAIT: begin
					if (seq_rvalid) begin
						if (field_idx == CMD_COLOR) begin
							state <= ST_START;
						end else begin
							field_idx <= field_idx + cmd_addr_t'(1);
							state     <= ST_FIELD_REQ;
						end
					end
				end
				// one-cycle launch
				ST_START: begin
					state <= ST_DRAW;
				end
				ST_DRAW: begin
					if (scan_done) begin
						state <= ST_CLEAR;
					end
				end
				// zero flag tells the host we are finished
				ST_CLEAR: begin
					if (seq_gnt) begin
						state <= ST_FLAG_REQ;
					end
				end
				default: begin
					state <= ST_FLAG_REQ;
				end
			endcase
		end
	end

	// ========================================================================
	// field capture
	// ========================================================================
	// low bits of each word, the rest is ignored
	always_ff @(posedge iCLK) begin
		if ((state == ST_FIELD_WAIT) && seq_rvalid) begin
			case (field_idx)
				CMD_X1:    x1    <= seq_rdata[COORD_W-1:0];
				CMD_Y1:    y1    <= seq_rdata[COORD_W-1:0];
				CMD_X2:    x2    <= seq_rdata[COORD_W-1:0];
				CMD_Y2:    y2    <= seq_rdata[COORD_W-1:0];
				CMD_COLOR: color <= seq_rdata[COLOR_W-1:0];
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== design/rect_scan.sv ====
module rect_scan (
	input  logic                iCLK,
	input  logic                rst,
	input  logic                scan_start,
	input  rect_pkg::coord_t    x1,
	input  rect_pkg::coord_t    y1,
	input  rect_pkg::coord_t    x2,
	input  rect_pkg::coord_t    y2,
	input  rect_pkg::color_t    color,
	output logic                pix_we,
	output rect_pkg::pix_addr_t pix_addr,
	output rect_pkg::color_t    pix_color,
	output logic                scan_done
);
	import rect_pkg::*;

	logic   active;
	logic   last_q;
	// next pixel to emit and the latched bounds
	coord_t cx, cy;
	coord_t x_lo, x_hi, y_hi;
	color_t col_q;
	// current pixel, taken straight from the inputs on the start cycle
	coord_t nx, ny, lx, hx, hy;
	color_t ncol;
	logic   emit;
	logic   last;

	// inverted corners collapse onto x1 / y1
	assign nx   = scan_start ? x1 : cx;
	assign ny   = scan_start ? y1 : cy;
	assign lx   = scan_start ? x1 : x_lo;
	assign hx   = scan_start ? ((x2 > x1) ? x2 : x1) : x_hi;
	assign hy   = scan_start ? ((y2 > y1) ? y2 : y1) : y_hi;
	assign ncol = scan_start ? color : col_q;

	assign emit = scan_start | active;
	assign last = (nx == hx) && (ny == hy);

	// bounds and colour held for the whole walk
	always_ff @(posedge iCLK) begin
		if (scan_start) begin
			x_lo  <= lx;
			x_hi  <= hx;
			y_hi  <= hy;
			col_q <= ncol;
		end
	end

	// ========================================================================
	// raster walk, x fastest
	// ========================================================================
	always_ff @(posedge iCLK) begin
		if (emit) begin
			pix_addr  <= pix_addr_t'(ny) * pix_addr_t'(FRAME_W) + pix_addr_t'(nx);
			pix_color <= ncol;
			// wrap to the row start at the right edge
			if (nx == hx) begin
				cx <= lx;
				cy <= ny + coord_t'(1);
			end else begin
				cx <= nx + coord_t'(1);
				cy <= ny;
			end
		end
	end

	// one write per cycle, done a cycle after the last one
	always_ff @(posedge iCLK) begin
		if (rst) begin
			active    <= 1'b0;
			pix_we    <= 1'b0;
			last_q    <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			active    <= emit & ~last;
			pix_we    <= emit;
			last_q    <= emit & last;
			scan_done <= last_q;
		end
	end

endmodule

// ==== design/rect_draw_top.sv ====
module rect_draw_top (
	input  logic                iCLK,
	input  logic                rst,
	// host access to the command memory
	input  logic                host_wr,
	input  logic                host_rd,
	input  rect_pkg::cmd_addr_t host_addr,
	input  rect_pkg::cmd_word_t host_wdata,
	output rect_pkg::cmd_word_t host_rdata,
	output logic                host_rd_valid,
	// frame buffer write port
	output logic                pix_we,
	output rect_pkg::pix_addr_t pix_addr,
	output rect_pkg::color_t    pix_color
);
	import rect_pkg::*;

	logic      seq_req, seq_we, seq_gnt, seq_rvalid;
	cmd_addr_t seq_addr;
	cmd_word_t seq_wdata, seq_rdata;

	logic      ram_we;
	cmd_addr_t ram_addr;
	cmd_word_t ram_wdata, ram_q;

	logic      scan_start, scan_done;
	coord_t    x1, y1, x2, y2;
	color_t    color;

	// ========================================================================
	// memory side
	// ========================================================================
	cmd_ram cmd_ram_i (
		.iCLK (iCLK),
		.we   (ram_we),
		.addr (ram_addr),
		.wdata(ram_wdata),
		.q    (ram_q)
	);

	// host first, engine in the gaps
	cmd_arbiter cmd_arbiter_i (
		.iCLK(iCLK), .rst(rst),
		.host_wr(host_wr), .host_rd(host_rd),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .host_rd_valid(host_rd_valid),
		.seq_req(seq_req), .seq_we(seq_we),
		.seq_addr(seq_addr), .seq_wdata(seq_wdata),
		.seq_gnt(seq_gnt), .seq_rvalid(seq_rvalid), .seq_rdata(seq_rdata),
		.ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_q(ram_q)
	);

	// ========================================================================
	// drawing side
	// ========================================================================
	cmd_sequencer cmd_sequencer_i (
		.iCLK(iCLK), .rst(rst),
		.seq_req(seq_req), .seq_we(seq_we),
		.seq_addr(seq_addr), .seq_wdata(seq_wdata),
		.seq_gnt(seq_gnt), .seq_rvalid(seq_rvalid), .seq_rdata(seq_rdata),
		.scan_start(scan_start),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .color(color),
		.scan_done(scan_done)
	);

	rect_scan rect_scan_i (
		.iCLK(iCLK), .rst(rst),
		.scan_start(scan_start),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .color(color),
		.pix_we(pix_we), .pix_addr(pix_addr), .pix_color(pix_color),
		.scan_done(scan_done)
	);

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
	output logic iCLK,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 16;

	// 20 ns period, first rising edge at 10 ns
	initial begin
		iCLK = 1'b0;
		forever #HALF_PERIOD iCLK = ~iCLK;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge iCLK);
		@(negedge iCLK);
		rst = 1'b0;
	end

endmodule

// ==== bench/rect_draw_sva.sv ====
module rect_draw_sva (
	input logic                iCLK,
	input logic                rst,
	input logic                host_wr,
	input logic                host_rd,
	input logic                host_rd_valid,
	input logic                pix_we,
	input rect_pkg::pix_addr_t pix_addr
);
	timeunit 1ns;
	timeprecision 100ps;
	import rect_pkg::*;

	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

	// ========================================================================
	// host read return
	// ========================================================================
	// a read is accepted unless a write shares its cycle
	rd_valid_follows: assert property (@(posedge iCLK) disable iff (rst)
		(host_rd && !host_wr) |=> host_rd_valid)
	else $error("accepted host read got no valid one cycle later");

	// and no valid shows up without such a read
	rd_valid_caused: assert property (@(posedge iCLK) disable iff (rst)
		host_rd_valid |-> $past(host_rd && !host_wr))
	else $error("host_rd_valid without an accepted read one cycle before");

	// ========================================================================
	// pixel port
	// ========================================================================
	// checked mid-cycle, the port is registered
	no_pix_in_reset: assert property (@(negedge iCLK)
		rst |-> !pix_we)
	else $error("pixel write while reset is high");

	pix_in_frame: assert property (@(posedge iCLK) disable iff (rst)
		pix_we |-> (pix_addr < pix_addr_t'(FRAME_PIXELS)))
	else $error("pixel address outside the frame");

endmodule

bind rect_draw_top rect_draw_sva sva_i (
	.iCLK         (iCLK),
	.rst          (rst),
	.host_wr      (host_wr),
	.host_rd      (host_rd),
	.host_rd_valid(host_rd_valid),
	.pix_we       (pix_we),
	.pix_addr     (pix_addr)
);

// ==== bench/rect_draw_tb.sv ====
module rect_draw_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rect_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_CMDS     = 4;
	localparam int CMD_OVERHEAD = 60;

	logic      iCLK;
	logic      rst;
	logic      host_wr;
	logic      host_rd;
	logic      host_rd_valid;
	logic      pix_we;
	cmd_addr_t host_addr;
	cmd_word_t host_wdata;
	cmd_word_t host_rdata;
	pix_addr_t pix_addr;
	color_t    pix_color;

	int        seed;
	int        cycle_count;
	int        limit;
	// host view of the command memory
	cmd_word_t shadow [256];
	// expected pixel stream with the oldest first
	pix_addr_t exp_addr [$];
	color_t    exp_color [$];
	// command list with corners, colour and host traffic rate in percent
	coord_t    cx1 [NUM_CMDS];
	coord_t    cy1 [NUM_CMDS];
	coord_t    cx2 [NUM_CMDS];
	coord_t    cy2 [NUM_CMDS];
	color_t    ccol [NUM_CMDS];
	int        crate [NUM_CMDS];

	tb_clock clk_gen_i (.iCLK(iCLK), .rst(rst));

	rect_draw_top dut_i (
		.iCLK(iCLK), .rst(rst),
		.host_wr(host_wr), .host_rd(host_rd),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .host_rd_valid(host_rd_valid),
		.pix_we(pix_we), .pix_addr(pix_addr), .pix_color(pix_color)
	);

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	// ========================================================================
	// host bus
	// ========================================================================
	// one bus cycle with the result looked at on the next falling edge
	task automatic host_cycle(input logic wr, input logic rd, input cmd_addr_t addr,
		input cmd_word_t wdata, output cmd_word_t rdata);
		host_wr    = wr;
		host_rd    = rd;
		host_addr  = addr;
		host_wdata = wdata;
		@(negedge iCLK);
		host_wr = 1'b0;
		host_rd = 1'b0;
		// write pre-empts a read in the same cycle
		assert (host_rd_valid === (rd & ~wr))
		else report_error($sformatf("host_rd_valid %b after rd %b wr %b",
			host_rd_valid, rd, wr));
		rdata = host_rdata;
		if (wr) begin
			shadow[addr] = wdata;
		end
	endtask

	task automatic host_write(input cmd_addr_t addr, input cmd_word_t data);
		cmd_word_t unused;
		host_cycle(1'b1, 1'b0, addr, data, unused);
	endtask

	task automatic host_idle();
		cmd_word_t unused;
		host_cycle(1'b0, 1'b0, '0, '0, unused);
	endtask

	task automatic host_read_check(input cmd_addr_t addr);
		cmd_word_t data;
		host_cycle(1'b0, 1'b1, addr, '0, data);
		assert (data === shadow[addr])
		else report_error($sformatf("word %0d read %h, expected %h",
			addr, data, shadow[addr]));
	endtask

	// random host access to the free words 6..255
	task automatic traffic_cycle(input int rate);
		int        pick;
		cmd_addr_t addr;
		pick = int'($unsigned($random(seed)) % 100);
		addr = cmd_addr_t'(6 + $unsigned($random(seed)) % 250);
		if (pick >= rate) begin
			host_idle();
		end else if (pick[0]) begin
			host_read_check(addr);
		end else begin
			host_write(addr, cmd_word_t'($random(seed)));
		end
	endtask

	// ========================================================================
	// reference model
	// ========================================================================
	// an inverted corner collapses onto the first one
	function automatic coord_t far_corner(input coord_t a, input coord_t b);
		return (b > a) ? b : a;
	endfunction

	function automatic int pixel_count(input int i);
		int w;
		int h;
		w = int'(far_corner(cx1[i], cx2[i])) - int'(cx1[i]) + 1;
		h = int'(far_corner(cy1[i], cy2[i])) - int'(cy1[i]) + 1;
		return w * h;
	endfunction

	task automatic set_cmd(input int i, input coord_t x1, input coord_t y1,
		input coord_t x2, input coord_t y2, input color_t col, input int rate);
		cx1[i]   = x1;
		cy1[i]   = y1;
		cx2[i]   = x2;
		cy2[i]   = y2;
		ccol[i]  = col;
		crate[i] = rate;
	endtask

	// ========================================================================
	// one command posted and polled until the engine clears the flag
	// ========================================================================
	task automatic run_command(input int i);
		cmd_word_t hi;
		cmd_word_t flag;
		cmd_word_t data;
		int        xe;
		int        ye;
		xe = int'(far_corner(cx1[i], cx2[i]));
		ye = int'(far_corner(cy1[i], cy2[i]));
		// row major with x fastest
		for (int y = int'(cy1[i]); y <= ye; y++) begin
			for (int x = int'(cx1[i]); x <= xe; x++) begin
				exp_addr.push_back(pix_addr_t'(y * FRAME_W + x));
				exp_color.push_back(ccol[i]);
			end
		end
		// junk above the field bits
		hi = cmd_word_t'($random(seed));
		host_write(CMD_X1, {hi[31:COORD_W], cx1[i]});
		host_write(CMD_Y1, {hi[31:COORD_W], cy1[i]});
		host_write(CMD_X2, {hi[31:COORD_W], cx2[i]});
		host_write(CMD_Y2, {hi[31:COORD_W], cy2[i]});
		host_write(CMD_COLOR, {hi[31:COLOR_W], ccol[i]});
		flag = cmd_word_t'($random(seed)) | cmd_word_t'(1);
		host_write(CMD_FLAG, flag);
		data = flag;
		while (data != '0) begin
			repeat (4) traffic_cycle(crate[i]);
			host_cycle(1'b0, 1'b1, CMD_FLAG, '0, data);
			assert (data === flag || data === '0)
			else report_error($sformatf("flag read %h while busy, posted %h", data, flag));
		end
		assert (exp_addr.size() == 0)
		else report_error($sformatf("flag cleared with %0d pixels missing", exp_addr.size()));
	endtask

	// pixel writes against the head of the expected stream
	always @(negedge iCLK) begin
		if (pix_we === 1'b1) begin
			if (exp_addr.size() == 0) begin
				report_error($sformatf("unexpected pixel write to %0d", pix_addr));
			end else begin
				assert (pix_addr === exp_addr[0] && pix_color === exp_color[0])
				else report_error($sformatf("pixel %0d colour %h, expected %0d colour %h",
					pix_addr, pix_color, exp_addr[0], exp_color[0]));
				void'(exp_addr.pop_front());
				void'(exp_color.pop_front());
			end
		end
	end

	always @(posedge iCLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int total;
		int rx;
		int ry;
		host_wr     = 1'b0;
		host_rd     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		seed        = 32'hf87e9205;
		cycle_count = 0;
		// plain 40 x 30, x2 below x1, both inverted, then random under traffic
		set_cmd(0, 10'd100, 10'd50, 10'd139, 10'd79, 8'h5a, 0);
		set_cmd(1, 10'd300, 10'd100, 10'd250, 10'd119, 8'hc3, 0);
		set_cmd(2, 10'd500, 10'd400, 10'd10, 10'd3, 8'h81, 0);
		rx = int'($unsigned($random(seed)) % 580);
		ry = int'($unsigned($random(seed)) % 440);
		set_cmd(3, coord_t'(rx), coord_t'(ry),
			coord_t'(rx + 15 + int'($unsigned($random(seed)) % 25)),
			coord_t'(ry + 15 + int'($unsigned($random(seed)) % 25)),
			color_t'($random(seed)), 20 + int'($unsigned($random(seed)) % 60));
		total = 0;
		for (int i = 0; i < NUM_CMDS; i++) begin
			total += pixel_count(i);
		end
		limit = 2 * (RESET_CYCLES + CMD_OVERHEAD * NUM_CMDS + total);

		// quiet outputs through reset
		@(posedge iCLK);
		repeat (RESET_CYCLES - 1) begin
			@(negedge iCLK);
			assert (pix_we === 1'b0 && host_rd_valid === 1'b0)
			else report_error("pix_we or host_rd_valid high during reset");
		end
		@(negedge rst);
		// idle engine so the monitor flags any pixel write
		host_write(CMD_FLAG, '0);
		repeat (50) host_idle();

		// free words write and read back
		for (int a = 6; a < 256; a++) begin
			host_write(cmd_addr_t'(a), cmd_word_t'($random(seed)));
		end
		for (int a = 6; a < 256; a++) begin
			host_read_check(cmd_addr_t'(a));
		end

		for (int i = 0; i < NUM_CMDS; i++) begin
			run_command(i);
		end

		// stray writes after the last clear show up here
		repeat (20) host_idle();

		$display("sim passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/rect_pkg.sv
design/cmd_ram.sv
design/cmd_arbiter.sv
design/cmd_sequencer.sv
design/rect_scan.sv
design/rect_draw_top.sv
bench/tb_clock.sv
bench/rect_draw_sva.sv
bench/rect_draw_tb.sv

// ==== Makefile ====
TOP = rect_draw_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
